//--- files.f
verilog/tcb_pkg.sv
verilog/rv_trace_pkg.sv
verilog/mouse_core.sv
verilog/tcb_mem.sv
verilog/tcb_trace_tap.sv
verilog/mouse_sys.sv
sim/mouse_tb.sv

//--- Makefile
# Verilator build and run for the mouse subsystem testbench

TOP = mouse_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv --top-module $(TOP) -f files.f

# the run passes only if the pass line shows up in the output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

//--- sim/mouse_tb.sv
`timescale 1ns/10ps

module mouse_tb
  import tcb_pkg::*;
  import rv_trace_pkg::*;
();

  localparam int MEM_WORDS = 512;
  // register block at byte 0x400
  localparam int GPR_WORD = 256;
  // records checked over all tests
  localparam int TOTAL_INS = 8 + 10 + 13 + 8 + 12 + 3 + 7;
  // bus cycles per instruction, worst case
  localparam int CPI_MAX = 12;
  // slowest ack plus handshake turnaround
  localparam int ACK_MAX = 10;
  localparam int WATCHDOG_NS = (TOTAL_INS * (CPI_MAX + ACK_MAX) + 7 * 8 + 64) * 8;

  logic     tcb = 1'b0;
  logic     arst_n;
  logic     trc_req;
  logic     trc_ack = 1'b0;
  trc_rec_t trc_rec;

  // receiver
  trc_rec_t rx_q[$];
  logic     rx_seen = 1'b0;
  int       rx_cnt = 0;
  int       ack_dly;
  bit       rnd_ack = 1'b0;
  int       seed = 29;

  // ISA model
  tcb_dat_t mdl_mem [MEM_WORDS];
  tcb_dat_t mdl_gpr [32];
  tcb_adr_t mdl_pc;
  trc_rec_t exp_q[$];
  ins_t     prog[$];

  int errors = 0;
  int test_err = 0;
  int tests_run = 0;
  int tests_bad = 0;

  mouse_sys dut_i (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .trc_req (trc_req),
    .trc_ack (trc_ack),
    .trc_rec (trc_rec)
  );

  always #4 tcb = ~tcb;

  //////////////////////////////
  // record receiver
  //////////////////////////////

  always @(posedge tcb) begin
    if (!arst_n) begin
      trc_ack <= 1'b0;
      rx_seen <= 1'b0;
    end else if (trc_ack) begin
      // back to idle once req drops
      if (!trc_req) begin
        trc_ack <= 1'b0;
        rx_seen <= 1'b0;
      end
    end else if (trc_req) begin
      if (!rx_seen) begin
        rx_q.push_back(trc_rec);
        rx_seen <= 1'b1;
        ack_dly = rnd_ack ? $unsigned($random(seed)) % 8 : 0;
        if (ack_dly == 0) begin
          trc_ack <= 1'b1;
        end else begin
          rx_cnt <= ack_dly - 1;
        end
      end else if (rx_cnt == 0) begin
        trc_ack <= 1'b1;
      end else begin
        rx_cnt <= rx_cnt - 1;
      end
    end
  end

  //////////////////////////////
  // instruction encoding
  //////////////////////////////

  function automatic ins_t lui_word(int rd, int imm);
    return {imm[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic ins_t addi_word(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  // ADD, or SUB with funct7 bit 5
  function automatic ins_t alu_word(int rd, int rs1, int rs2, bit sub);
    return {1'b0, sub, 5'b00000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic ins_t lw_word(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
  endfunction

  // SW when word is set, else SB
  function automatic ins_t store_word(int rs2, int rs1, int imm, bit word);
    return {imm[11:5], rs2[4:0], rs1[4:0], word ? 3'b010 : 3'b000, imm[4:0], 7'b0100011};
  endfunction

  // BNE when ne is set, else BEQ
  function automatic ins_t branch_word(int rs1, int rs2, int off, bit ne);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], ne ? 3'b001 : 3'b000,
            off[4:1], off[11], 7'b1100011};
  endfunction

  //////////////////////////////
  // ISA model
  //////////////////////////////

  // one instruction, returns its commit record
  function automatic trc_rec_t step_model();
    trc_rec_t r;
    ins_t     w;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [4:0] rd;
    tcb_dat_t a;
    tcb_dat_t b;
    tcb_dat_t res;
    tcb_adr_t adr;
    tcb_adr_t nxt;
    bit       wr;
    r = '0;
    res = '0;
    wr = 1'b0;
    w = mdl_mem[mdl_pc[10:2]];
    opc = w[6:0];
    f3 = w[14:12];
    rd = w[11:7];
    a = mdl_gpr[w[19:15]];
    b = mdl_gpr[w[24:20]];
    nxt = mdl_pc + 4;
    r.pc = mdl_pc;
    r.ins = w;
    case (opc)
      7'b0110111: begin
        wr = 1'b1;
        res = {w[31:12], 12'h000};
      end
      7'b0010011: begin
        wr = 1'b1;
        res = a + {{20{w[31]}}, w[31:20]};
      end
      7'b0110011: begin
        wr = 1'b1;
        res = w[30] ? a - b : a + b;
      end
      7'b0000011: begin
        wr = 1'b1;
        adr = a + {{20{w[31]}}, w[31:20]};
        r.ld_vld = 1'b1;
        r.ld_adr = adr;
        res = mdl_mem[adr[10:2]];
      end
      7'b0100011: begin
        adr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        r.st_vld = 1'b1;
        r.st_adr = adr;
        if (f3 == 3'b000) begin
          // byte lane picked by the low address bits
          r.st_siz = 2'd0;
          r.st_dat = {24'h0, b[7:0]};
          mdl_mem[adr[10:2]][8*adr[1:0] +: 8] = b[7:0];
        end else begin
          r.st_siz = 2'd2;
          r.st_dat = b;
          mdl_mem[adr[10:2]] = b;
        end
      end
      7'b1100011: begin
        if ((f3 == 3'b001) ? (a != b) : (a == b)) begin
          nxt = mdl_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      default: ;
    endcase
    // x0 keeps zero, so no write-back at all
    if (wr && rd != 5'd0) begin
      r.wb_vld = 1'b1;
      r.wb_idx = rd;
      r.wb_dat = res;
      mdl_gpr[rd] = res;
    end
    mdl_pc = nxt;
    return r;
  endfunction

  //////////////////////////////
  // test helpers
  //////////////////////////////

  // program at 0, zeroed GPRs, fill pattern elsewhere
  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (i < prog.size()) begin
        mdl_mem[i] = prog[i];
      end else if (i >= GPR_WORD && i < GPR_WORD + 32) begin
        mdl_mem[i] = '0;
      end else begin
        mdl_mem[i] = {~i[15:0], i[15:0]};
      end
      dut_i.mem_i.mem[i] = mdl_mem[i];
    end
    for (int r = 0; r < 32; r++) begin
      mdl_gpr[r] = '0;
    end
    mdl_pc = '0;
  endtask

  task automatic build_expected(int n);
    exp_q.delete();
    for (int k = 0; k < n; k++) begin
      exp_q.push_back(step_model());
    end
  endtask

  // load while in reset, three cycles
  task automatic restart_program(int n);
    @(posedge tcb);
    arst_n <= 1'b0;
    @(posedge tcb);
    load_program();
    build_expected(n);
    rx_q.delete();
    repeat (2) @(posedge tcb);
    arst_n <= 1'b1;
  endtask

  task automatic wait_records(int n);
    int waited;
    waited = 0;
    while (rx_q.size() < n && waited < n * (CPI_MAX + ACK_MAX)) begin
      @(posedge tcb);
      waited++;
    end
    assert (rx_q.size() >= n)
      else begin
        $display("only %0d of %0d records arrived in time", rx_q.size(), n);
        test_err++;
      end
  endtask

  task automatic compare_field(string name, int k, tcb_dat_t exp, tcb_dat_t act);
    assert (act === exp)
      else begin
        $display("ERR record %0d %s expected %h actual %h", k, name, exp, act);
        test_err++;
      end
  endtask

  // event fields only count where the event happened
  task automatic check_records(int n);
    trc_rec_t e;
    trc_rec_t a;
    for (int k = 0; k < n && k < rx_q.size(); k++) begin
      e = exp_q[k];
      a = rx_q[k];
      compare_field("pc", k, e.pc, a.pc);
      compare_field("ins", k, e.ins, a.ins);
      compare_field("wb_vld", k, 32'(e.wb_vld), 32'(a.wb_vld));
      compare_field("ld_vld", k, 32'(e.ld_vld), 32'(a.ld_vld));
      compare_field("st_vld", k, 32'(e.st_vld), 32'(a.st_vld));
      if (e.wb_vld) begin
        compare_field("wb_idx", k, 32'(e.wb_idx), 32'(a.wb_idx));
        compare_field("wb_dat", k, e.wb_dat, a.wb_dat);
      end
      if (e.ld_vld) begin
        compare_field("ld_adr", k, e.ld_adr, a.ld_adr);
      end
      if (e.st_vld) begin
        compare_field("st_adr", k, e.st_adr, a.st_adr);
        compare_field("st_siz", k, 32'(e.st_siz), 32'(a.st_siz));
        compare_field("st_dat", k, e.st_dat, a.st_dat);
      end
    end
  endtask

  task automatic report_test(string name, int n);
    tests_run++;
    if (test_err == 0) begin
      $display("test %s: %0d records match", name, n);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, test_err);
    end
    errors += test_err;
    test_err = 0;
  endtask

  task automatic run_and_check(string name, int n);
    restart_program(n);
    wait_records(n);
    check_records(n);
    report_test(name, n);
  endtask

  // ends in a BEQ onto itself
  task automatic put_arith_program();
    prog.delete();
    prog.push_back(lui_word(1, 'h12345));
    prog.push_back(addi_word(2, 1, 'h678));
    prog.push_back(addi_word(3, 0, -5));
    prog.push_back(alu_word(4, 2, 3, 1'b0));
    prog.push_back(alu_word(5, 2, 3, 1'b1));
    prog.push_back(alu_word(6, 3, 2, 1'b1));
    prog.push_back(addi_word(7, 7, 1));
    prog.push_back(branch_word(0, 0, 0, 1'b0));
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic arith_test();
    put_arith_program();
    run_and_check("arith", 8);
  endtask

  // word and byte stores, then loads of the merged words
  task automatic memory_test();
    prog.delete();
    prog.push_back(addi_word(1, 0, 'h200));
    prog.push_back(lui_word(2, 'hDEADB));
    prog.push_back(addi_word(2, 2, -'h111));
    prog.push_back(store_word(2, 1, 0, 1'b1));
    prog.push_back(addi_word(3, 0, 'h7C));
    prog.push_back(store_word(3, 1, 1, 1'b0));
    prog.push_back(lw_word(4, 1, 0));
    prog.push_back(store_word(2, 1, 7, 1'b0));
    prog.push_back(lw_word(5, 1, 4));
    prog.push_back(branch_word(0, 0, 0, 1'b0));
    run_and_check("memory", 10);
  endtask

  // taken and not taken, plus a short countdown loop
  task automatic branch_test();
    prog.delete();
    prog.push_back(addi_word(1, 0, 3));
    prog.push_back(addi_word(2, 0, 3));
    prog.push_back(branch_word(1, 2, 8, 1'b0));
    prog.push_back(addi_word(3, 0, 1));
    prog.push_back(branch_word(1, 2, 8, 1'b1));
    prog.push_back(addi_word(4, 0, 2));
    prog.push_back(addi_word(1, 1, -1));
    prog.push_back(branch_word(1, 0, -4, 1'b1));
    prog.push_back(branch_word(1, 2, 8, 1'b0));
    prog.push_back(branch_word(0, 0, 0, 1'b0));
    run_and_check("branch", 13);
  endtask

  task automatic zero_reg_test();
    prog.delete();
    prog.push_back(addi_word(0, 0, 5));
    prog.push_back(lui_word(0, 'hFFFFF));
    prog.push_back(alu_word(1, 0, 0, 1'b0));
    prog.push_back(addi_word(2, 0, 9));
    prog.push_back(alu_word(3, 0, 2, 1'b1));
    prog.push_back(alu_word(0, 2, 2, 1'b0));
    prog.push_back(alu_word(4, 0, 2, 1'b0));
    prog.push_back(branch_word(0, 0, 0, 1'b0));
    run_and_check("x0", 8);
  endtask

  // slow random acks stall the fetches
  task automatic backpressure_test();
    put_arith_program();
    rnd_ack = 1'b1;
    run_and_check("backpressure", 12);
    rnd_ack = 1'b0;
  endtask

  // every register is written before it is read
  task automatic reset_test();
    prog.delete();
    prog.push_back(addi_word(1, 0, 1));
    prog.push_back(addi_word(2, 1, 2));
    prog.push_back(alu_word(3, 1, 2, 1'b0));
    prog.push_back(alu_word(4, 3, 1, 1'b1));
    prog.push_back(addi_word(1, 1, 4));
    prog.push_back(lui_word(5, 'hABCDE));
    prog.push_back(branch_word(0, 0, 0, 1'b0));
    restart_program(7);
    wait_records(3);
    // cut the program short mid instruction
    @(posedge tcb);
    arst_n <= 1'b0;
    @(posedge tcb);
    rx_q.delete();
    repeat (2) @(posedge tcb);
    arst_n <= 1'b1;
    wait_records(7);
    if (rx_q.size() > 0) begin
      compare_field("first pc", 0, 32'h0, rx_q[0].pc);
    end
    check_records(7);
    report_test("reset", 7);
  endtask

  //////////////////////////////
  // sequence and watchdog
  //////////////////////////////

  initial begin
    arst_n = 1'b0;
    arith_test();
    memory_test();
    branch_test();
    zero_reg_test();
    backpressure_test();
    reset_test();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("Something failed");
    $finish;
  end

endmodule

//--- verilog/mouse_sys.sv
`timescale 1ns/10ps

module mouse_sys
  import tcb_pkg::*;
  import rv_trace_pkg::*;
#(
  parameter tcb_adr_t RESET_PC  = 32'h0000_0000,
  parameter tcb_adr_t GPR_BASE  = 32'h0000_0400,
  parameter int       MEM_WORDS = 512
)(
  input  logic     tcb,
  input  logic     arst_n,
  output logic     trc_req,
  input  logic     trc_ack,
  output trc_rec_t trc_rec
);

  // core to tap
  logic     core_vld;
  logic     core_rdy;
  tcb_req_t core_req;
  tcb_rsp_t core_rsp;
  pha_t     core_pha;

  // tap to memory
  logic     mem_vld;
  logic     mem_rdy;
  tcb_req_t mem_req;
  tcb_rsp_t mem_rsp;

  mouse_core #(
    .RESET_PC (RESET_PC),
    .GPR_BASE (GPR_BASE)
  ) core_i (
    .tcb    (tcb),
    .arst_n (arst_n),
    .vld    (core_vld),
    .req    (core_req),
    .rdy    (core_rdy),
    .rsp    (core_rsp),
    .pha    (core_pha)
  );

  tcb_trace_tap tap_i (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .pha     (core_pha),
    .man_vld (core_vld),
    .man_req (core_req),
    .man_rdy (core_rdy),
    .man_rsp (core_rsp),
    .sub_vld (mem_vld),
    .sub_req (mem_req),
    .sub_rdy (mem_rdy),
    .sub_rsp (mem_rsp),
    .trc_req (trc_req),
    .trc_ack (trc_ack),
    .trc_rec (trc_rec)
  );

  tcb_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) mem_i (
    .tcb    (tcb),
    .arst_n (arst_n),
    .vld    (mem_vld),
    .req    (mem_req),
    .rdy    (mem_rdy),
    .rsp    (mem_rsp)
  );

endmodule

//--- verilog/tcb_trace_tap.sv
`timescale 1ns/10ps

module tcb_trace_tap
  import tcb_pkg::*;
  import rv_trace_pkg::*;
(
  input  logic     tcb,
  input  logic     arst_n,
  // phase of the current request
  input  pha_t     pha,
  // manager side
  input  logic     man_vld,
  input  tcb_req_t man_req,
  output logic     man_rdy,
  output tcb_rsp_t man_rsp,
  // subordinate side
  output logic     sub_vld,
  output tcb_req_t sub_req,
  input  logic     sub_rdy,
  input  tcb_rsp_t sub_rsp,
  // trace output, four-phase
  output logic     trc_req,
  input  logic     trc_ack,
  output trc_rec_t trc_rec
);

  logic     trn;
  // previous record still in its handshake
  logic     hold;
  // delayed transfer sample
  logic     dly_trn;
  pha_t     dly_pha;
  tcb_req_t dly_req;
  // no record for the first fetch
  logic     first;
  logic     rec_go;
  tcb_dat_t st_dat;
  // record of the instruction in flight
  trc_rec_t cur;

  //////////////////////////////
  // bus path
  //////////////////////////////

  assign hold = trc_req | trc_ack;

  assign sub_vld = man_vld;
  assign sub_req = man_req;
  assign man_rsp = sub_rsp;
  // only fetches wait, the rest of an instruction runs on
  assign man_rdy = sub_rdy & ~(hold & (pha == IF));

  assign trn = man_vld & man_rdy;

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      dly_trn <= 1'b0;
    end else begin
      dly_trn <= trn;
    end
  end

  always_ff @(posedge tcb) begin
    if (trn) begin
      dly_pha <= pha;
      dly_req <= man_req;
    end
  end

  //////////////////////////////
  // record assembly
  //////////////////////////////

  // store data cut to size
  always_comb begin
    case (dly_req.siz)
      SIZ_BYTE: st_dat = {24'h0, dly_req.wdt[7:0]};
      SIZ_HALF: st_dat = {16'h0, dly_req.wdt[15:0]};
      default: st_dat = dly_req.wdt;
    endcase
  end

  // fetch response closes the previous instruction
  assign rec_go = dly_trn & (dly_pha == IF) & ~first;

  always_ff @(posedge tcb) begin
    if (rec_go) begin
      trc_rec <= cur;
    end
    if (dly_trn) begin
      case (dly_pha)
        IF: cur <= '{pc: dly_req.adr, ins: sub_rsp.rdt, default: '0};
        WB: begin
          cur.wb_vld <= 1'b1;
          // register block is aligned
          cur.wb_idx <= dly_req.adr[2+:5];
          cur.wb_dat <= dly_req.wdt;
        end
        MLD: begin
          cur.ld_vld <= 1'b1;
          cur.ld_adr <= dly_req.adr;
        end
        MST: begin
          cur.st_vld <= 1'b1;
          cur.st_adr <= dly_req.adr;
          cur.st_siz <= dly_req.siz;
          cur.st_dat <= st_dat;
        end
        // source reads are not traced
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // four-phase handshake
  //////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      first   <= 1'b1;
      trc_req <= 1'b0;
    end else begin
      if (dly_trn && (dly_pha == IF)) begin
        first <= 1'b0;
      end
      if (rec_go) begin
        trc_req <= 1'b1;
      end else if (trc_req && trc_ack) begin
        trc_req <= 1'b0;
      end
    end
  end

  // req only drops after ack
  assert property (@(posedge tcb) disable iff (!arst_n)
    $fell(trc_req) |-> $past(trc_ack));

  // record holds until acknowledged
  assert property (@(posedge tcb) disable iff (!arst_n)
    trc_req && !trc_ack |=> $stable(trc_rec));

endmodule

//--- verilog/tcb_mem.sv
`timescale 1ns/10ps

module tcb_mem
  import tcb_pkg::*;
#(
  parameter int MEM_WORDS = 512
)(
  input  logic     tcb,
  input  logic     arst_n,
  input  logic     vld,
  input  tcb_req_t req,
  output logic     rdy,
  output tcb_rsp_t rsp
);

  localparam int AW = $clog2(MEM_WORDS);

  // word array
  tcb_dat_t mem [MEM_WORDS];

  logic          trn;
  logic [AW-1:0] idx;
  logic [4-1:0]  ben;

  // never stalls
  assign rdy = 1'b1;
  assign trn = vld & rdy;

  // word index from byte address
  assign idx = req.adr[2+:AW];

  // byte enables from size and low address bits
  always_comb begin
    case (req.siz)
      SIZ_BYTE: ben = 4'b0001 << req.adr[1:0];
      SIZ_HALF: ben = 4'b0011 << {req.adr[1], 1'b0};
      default: ben = 4'b1111;
    endcase
  end

  // write at the transfer edge, per lane
  always @(posedge tcb) begin
    if (trn && req.wen) begin
      for (int b = 0; b < 4; b++) begin
        if (ben[b]) begin
          mem[idx][8*b+:8] <= req.wdt[8*b+:8];
        end
      end
    end
  end

  // read data, next cycle
  always_ff @(posedge tcb) begin
    if (trn && !req.wen) begin
      rsp.rdt <= mem[idx];
    end
  end

  // all accesses stay inside the array
  assert property (@(posedge tcb) disable iff (!arst_n)
    trn |-> (req.adr >> 2) < tcb_adr_t'(MEM_WORDS));

endmodule

//--- verilog/mouse_core.sv
`timescale 1ns/10ps

module mouse_core
  import tcb_pkg::*;
  import rv_trace_pkg::*;
#(
  parameter tcb_adr_t RESET_PC = 32'h0000_0000,
  parameter tcb_adr_t GPR_BASE = 32'h0000_0400
)(
  input  logic     tcb,
  input  logic     arst_n,
  output logic     vld,
  output tcb_req_t req,
  input  logic     rdy,
  input  tcb_rsp_t rsp,
  output pha_t     pha
);

  //////////////////////////////
  // state and decode
  //////////////////////////////

  // bus transfer and pending read response
  logic     trn;
  logic     rsp_due;
  // phase work finished this cycle
  logic     done;
  logic     start;
  pha_t     pha_nxt;
  logic     bus_nxt;

  tcb_adr_t pc;
  tcb_adr_t pc_nxt;
  ins_t     ins_q;
  ins_t     ins_cur;
  // operands, rs2_dat also takes load data
  tcb_dat_t rs1_dat;
  tcb_dat_t rs2_dat;
  tcb_dat_t wb_dat;
  logic     taken;

  opc_t     opc;
  fn3_t     f3;
  gpr_idx_t rs1;
  gpr_idx_t rs2;
  gpr_idx_t rd;
  tcb_dat_t imm_i;
  tcb_dat_t imm_s;
  tcb_dat_t imm_b;
  tcb_dat_t imm_u;

  assign trn = vld & rdy;

  // write ends its phase at the transfer, read one cycle later
  // phases without bus access end right away
  assign done  = rsp_due | (trn & req.wen) | (~vld & ~rsp_due & (pha != IF));
  // idle fetch only exists right after reset
  assign start = ~vld & ~rsp_due & (pha == IF);

  // fresh instruction word arrives with the fetch response
  assign ins_cur = (pha == IF) ? rsp.rdt : ins_q;

  assign opc = ins_cur[6:0];
  assign f3  = ins_cur[14:12];
  assign rd  = ins_cur[11:7];
  assign rs1 = ins_cur[19:15];
  assign rs2 = ins_cur[24:20];

  assign imm_i = {{20{ins_cur[31]}}, ins_cur[31:20]};
  assign imm_s = {{20{ins_cur[31]}}, ins_cur[31:25], ins_cur[11:7]};
  assign imm_b = {{19{ins_cur[31]}}, ins_cur[31], ins_cur[7], ins_cur[30:25],
                  ins_cur[11:8], 1'b0};
  assign imm_u = {ins_cur[31:12], 12'h000};

  // branch condition, only BEQ and BNE
  assign taken = (f3 == F3_BNE) ? (rs1_dat != rs2_dat) : (rs1_dat == rs2_dat);

  assign pc_nxt = ((pha == EXE) && taken) ? pc + imm_b : pc + 32'd4;

  // phase sequence per opcode
  always_comb begin
    pha_nxt = IF;
    case (pha)
      IF: begin
        case (opc)
          OPC_LUI: pha_nxt = WB;
          OPC_OP_IMM, OPC_OP, OPC_LOAD, OPC_STORE, OPC_BRANCH: pha_nxt = RS1;
          // unsupported, move on
          default: pha_nxt = IF;
        endcase
      end
      RS1: begin
        case (opc)
          OPC_OP, OPC_STORE, OPC_BRANCH: pha_nxt = RS2;
          OPC_LOAD: pha_nxt = MLD;
          default: pha_nxt = WB;
        endcase
      end
      RS2: begin
        case (opc)
          OPC_OP: pha_nxt = WB;
          OPC_STORE: pha_nxt = MST;
          default: pha_nxt = EXE;
        endcase
      end
      MLD: pha_nxt = WB;
      default: pha_nxt = IF;
    endcase
  end

  // x0 accesses stay off the bus
  always_comb begin
    case (pha_nxt)
      RS1: bus_nxt = (rs1 != '0);
      RS2: bus_nxt = (rs2 != '0);
      WB: bus_nxt = (rd != '0);
      EXE: bus_nxt = 1'b0;
      default: bus_nxt = 1'b1;
    endcase
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      pha     <= IF;
      vld     <= 1'b0;
      rsp_due <= 1'b0;
      pc      <= RESET_PC;
    end else begin
      rsp_due <= trn & ~req.wen;
      if (trn) begin
        vld <= 1'b0;
      end
      if (done) begin
        pha <= pha_nxt;
        vld <= bus_nxt;
        // pc moves on as the instruction ends
        if (pha_nxt == IF) begin
          pc <= pc_nxt;
        end
      end else if (start) begin
        vld <= 1'b1;
      end
    end
  end

  // captured bus data
  always_ff @(posedge tcb) begin
    if (done) begin
      case (pha)
        IF: ins_q <= rsp.rdt;
        RS1: rs1_dat <= rsp_due ? rsp.rdt : '0;
        RS2, MLD: rs2_dat <= rsp_due ? rsp.rdt : '0;
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // request
  //////////////////////////////

  always_comb begin
    case (opc)
      OPC_LUI: wb_dat = imm_u;
      OPC_OP_IMM: wb_dat = rs1_dat + imm_i;
      // funct7 bit 5 picks SUB
      OPC_OP: wb_dat = ins_cur[30] ? rs1_dat - rs2_dat : rs1_dat + rs2_dat;
      // load result
      default: wb_dat = rs2_dat;
    endcase
  end

  always_comb begin
    req = '{wen: 1'b0, adr: pc, siz: SIZ_WORD, wdt: '0};
    case (pha)
      RS1: req.adr = GPR_BASE + (tcb_adr_t'(rs1) << 2);
      RS2: req.adr = GPR_BASE + (tcb_adr_t'(rs2) << 2);
      MLD: req.adr = rs1_dat + imm_i;
      MST: begin
        req.wen = 1'b1;
        req.adr = rs1_dat + imm_s;
        // byte goes out on every lane
        if (f3 == F3_SB) begin
          req.siz = SIZ_BYTE;
          req.wdt = {4{rs2_dat[7:0]}};
        end else begin
          req.wdt = rs2_dat;
        end
      end
      WB: begin
        req.wen = 1'b1;
        req.adr = GPR_BASE + (tcb_adr_t'(rd) << 2);
        req.wdt = wb_dat;
      end
      default: ;
    endcase
  end

  // stalled request holds until taken
  assert property (@(posedge tcb) disable iff (!arst_n)
    vld && !rdy |=> vld && $stable(req));

endmodule

//--- verilog/rv_trace_pkg.sv
package rv_trace_pkg;

  import tcb_pkg::*;

  //////////////////////////////
  // ISA field types
  //////////////////////////////

  // register index
  typedef logic [5-1:0] gpr_idx_t;
  // instruction word
  typedef logic [32-1:0] ins_t;
  // major opcode field
  typedef logic [7-1:0] opc_t;
  // funct3 field
  typedef logic [3-1:0] fn3_t;

  // execution phases, also the core FSM states
  // GPR accesses share the top bit
  typedef enum logic [3-1:0] {
    IF  = 3'b000,
    MLD = 3'b001,
    MST = 3'b010,
    EXE = 3'b011,
    WB  = 3'b100,
    RS1 = 3'b101,
    RS2 = 3'b110
  } pha_t;

  // opcodes of the supported subset
  localparam opc_t OPC_LUI    = 7'b0110111;
  localparam opc_t OPC_OP_IMM = 7'b0010011;
  localparam opc_t OPC_OP     = 7'b0110011;
  localparam opc_t OPC_LOAD   = 7'b0000011;
  localparam opc_t OPC_STORE  = 7'b0100011;
  localparam opc_t OPC_BRANCH = 7'b1100011;

  // funct3 values that change behavior
  // SB vs SW
  localparam fn3_t F3_SB  = 3'b000;
  // BNE vs BEQ
  localparam fn3_t F3_BNE = 3'b001;

  //////////////////////////////
  // commit record
  //////////////////////////////

  typedef struct packed {
    tcb_adr_t pc;
    ins_t     ins;
    // GPR write-back
    logic     wb_vld;
    gpr_idx_t wb_idx;
    tcb_dat_t wb_dat;
    // load
    logic     ld_vld;
    tcb_adr_t ld_adr;
    // store, data masked to size
    logic     st_vld;
    tcb_adr_t st_adr;
    tcb_siz_t st_siz;
    tcb_dat_t st_dat;
  } trc_rec_t;

endpackage

//--- verilog/tcb_pkg.sv
package tcb_pkg;

  //////////////////////////////
  // bus field types
  //////////////////////////////

  // byte address
  typedef logic [32-1:0] tcb_adr_t;

  // data word, four byte lanes
  typedef logic [32-1:0] tcb_dat_t;

  // log2 of transfer size in bytes
  typedef logic [2-1:0] tcb_siz_t;

  // size encodings
  localparam tcb_siz_t SIZ_BYTE = 2'd0;
  localparam tcb_siz_t SIZ_HALF = 2'd1;
  localparam tcb_siz_t SIZ_WORD = 2'd2;

  //////////////////////////////
  // transfer structs
  //////////////////////////////

  // request, held by the manager until rdy
  typedef struct packed {
    // write enable
    logic     wen;
    tcb_adr_t adr;
    tcb_siz_t siz;
    // write data, lanes placed by address
    tcb_dat_t wdt;
  } tcb_req_t;

  // response, one cycle after the transfer
  typedef struct packed {
    tcb_dat_t rdt;
  } tcb_rsp_t;

endpackage
